//--- source/dab_consts.svh
`ifndef DAB_CONSTS_SVH
`define DAB_CONSTS_SVH

// word formats
`define WORD_W    32
`define FRAC_BITS 16
`define ANGLE_W   9

////////////////////////////////////////
// Q16.16 constants

`define ONE         32'sd65536
`define TURNS_RATIO 32'sd360448     // n1/n2 = 5.5
`define K_FEAS      32'sd131072     // 2.0
`define K_PHI       32'sd411775     // 4*pi*L at nominal fs
`define ANGLE_SCALE 32'sd5319493    // 255/pi

////////////////////////////////////////
// angle codes

// full half period
`define TAU_FULL 9'sd255

// values after reset
`define TAU1_RST 9'sd255
`define TAU2_RST 9'sd147
`define PHI_RST  (-9'sd9)

`endif

//--- source/dab_pkg.sv
`include "dab_consts.svh"

package dab_pkg;

  typedef logic signed [`WORD_W-1:0]  fixed_t;   // Q16.16
  typedef logic signed [`ANGLE_W-1:0] angle_t;   // -256..255

  // calculator steps
  typedef enum logic [2:0] {
    IDLE,
    SCALE,
    DIV_RATIO,
    FEAS,
    DIV_PHI,
    ANGLES,
    DONE
  } calc_state_t;

  typedef enum logic [1:0] {
    MODE_APPLIED = 2'd0,
    MODE_HELD    = 2'd3
  } mode_t;

endpackage

//--- source/fx_divider.sv
`timescale 1ns/1ps
`include "dab_consts.svh"

module fx_divider
(
  input  logic            clk,
  input  logic            rst,
  input  logic            div_valid,
  output logic            div_ready,
  input  dab_pkg::fixed_t div_dividend,
  input  dab_pkg::fixed_t div_divisor,
  output logic            quot_valid,
  output dab_pkg::fixed_t quotient
);

  localparam int NUM_W = `WORD_W + `FRAC_BITS;
  localparam int STEPS = NUM_W / 2;    // radix 4
  localparam int LAST  = `WORD_W + 1;

  logic               busy;
  logic [5:0]         cnt;
  logic               neg;
  logic               den_zero;
  logic [`WORD_W-1:0] den;
  logic [`WORD_W-1:0] rem;
  logic [NUM_W-1:0]   num;             // dividend bits out, quotient bits in
  logic [`WORD_W-1:0] mag_a;
  logic [`WORD_W-1:0] mag_b;
  logic [`WORD_W:0]   step1;
  logic [`WORD_W:0]   step2;
  logic [`WORD_W-1:0] q_low;

  // {quotient bit, new remainder}
  function automatic logic [`WORD_W:0] div_step(input logic [`WORD_W-1:0] r,
                                                input logic               b,
                                                input logic [`WORD_W-1:0] d);
    logic [`WORD_W:0] trial;
    logic [`WORD_W:0] diff;
    trial = {r, b};
    diff  = trial - {1'b0, d};
    if (trial >= {1'b0, d})
      return {1'b1, diff[`WORD_W-1:0]};
    return {1'b0, trial[`WORD_W-1:0]};
  endfunction

  always_comb
  begin
    mag_a = div_dividend[`WORD_W-1] ? -div_dividend : div_dividend;
    mag_b = div_divisor[`WORD_W-1] ? -div_divisor : div_divisor;
    step1 = div_step(rem, num[NUM_W-1], den);
    step2 = div_step(step1[`WORD_W-1:0], num[NUM_W-2], den);
    q_low = num[`WORD_W-1:0];
  end

  assign div_ready = ~busy;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy       <= 1'b0;
      cnt        <= '0;
      quot_valid <= 1'b0;
    end
    else
    begin
      quot_valid <= 1'b0;
      if (div_valid && div_ready)
      begin
        busy <= 1'b1;
        cnt  <= '0;
      end
      else if (busy)
      begin
        cnt <= cnt + 6'd1;
        if (cnt == LAST)
        begin
          busy       <= 1'b0;
          quot_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (div_valid && div_ready)
    begin
      den      <= mag_b;
      rem      <= '0;
      num      <= {mag_a, {`FRAC_BITS{1'b0}}};
      neg      <= div_dividend[`WORD_W-1] ^ div_divisor[`WORD_W-1];
      den_zero <= (div_divisor == '0);
    end
    else if (busy)
    begin
      if (cnt < STEPS)
      begin
        rem <= step2[`WORD_W-1:0];
        num <= {num[NUM_W-3:0], step1[`WORD_W], step2[`WORD_W]};
      end
      if (cnt == LAST)
        quotient <= den_zero ? {1'b0, {(`WORD_W-1){1'b1}}} : (neg ? -q_low : q_low);
    end
  end

endmodule

//--- source/modulation_calc.sv
`timescale 1ns/1ps
`include "dab_consts.svh"

module modulation_calc
(
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  output logic            in_ready,
  input  dab_pkg::fixed_t vdc1,
  input  dab_pkg::fixed_t vdc2,
  input  dab_pkg::fixed_t iref,
  input  dab_pkg::fixed_t fs,           // acts only through K_PHI
  output logic            div_valid,
  input  logic            div_ready,
  output dab_pkg::fixed_t div_dividend,
  output dab_pkg::fixed_t div_divisor,
  input  logic            quot_valid,
  input  dab_pkg::fixed_t quotient,
  output logic            result_valid,
  output logic            feasible,
  output dab_pkg::angle_t tau1_new,
  output dab_pkg::angle_t tau2_new,
  output dab_pkg::angle_t phi_new
);

  import dab_pkg::*;

  calc_state_t state;

  fixed_t vdc1_r;
  fixed_t vdc2_r;
  fixed_t iref_r;
  fixed_t ratio;                        // vdc1 / vdc2p
  fixed_t aux;
  fixed_t phi_rad;

  angle_t                     tau1_code;
  logic signed [`WORD_W-1:0]  tau2_sum;

  ////////////////////////////////////////
  // fixed-point helpers

  function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
    logic signed [2*`WORD_W-1:0] wa;
    logic signed [2*`WORD_W-1:0] wb;
    logic signed [2*`WORD_W-1:0] p;
    wa = a;
    wb = b;
    p  = wa * wb;
    return fixed_t'(p >>> `FRAC_BITS);
  endfunction

  function automatic angle_t sat_code(input logic signed [`WORD_W-1:0] v);
    if (v > 255)
      return 9'sd255;
    if (v < -256)
      return -9'sd256;
    return angle_t'(v);
  endfunction

  // integer part of a Q16.16 word
  function automatic angle_t to_code(input fixed_t x);
    return sat_code(x >>> `FRAC_BITS);
  endfunction

  always_comb
  begin
    tau1_code = to_code(fx_mul(ratio, `ANGLE_SCALE));
    tau2_sum  = to_code(fx_mul(`ONE - ratio, `ANGLE_SCALE)) + tau1_code;
  end

  assign in_ready = (state == IDLE);

  ////////////////////////////////////////
  // sequencer

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state        <= IDLE;
      div_valid    <= 1'b0;
      result_valid <= 1'b0;
    end
    else
    begin
      if (div_valid && div_ready)
        div_valid <= 1'b0;              // operands taken
      case (state)
        IDLE:
          if (in_valid)
            state <= SCALE;
        SCALE:
        begin
          div_valid <= 1'b1;
          state     <= DIV_RATIO;
        end
        DIV_RATIO:
          if (quot_valid)
            state <= FEAS;
        FEAS:
        begin
          div_valid <= 1'b1;
          state     <= DIV_PHI;
        end
        DIV_PHI:
          if (quot_valid)
            state <= ANGLES;
        ANGLES:
        begin
          result_valid <= 1'b1;
          state        <= DONE;
        end
        DONE:
        begin
          result_valid <= 1'b0;
          state        <= IDLE;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // datapath registers
  always_ff @(posedge clk)
  begin
    case (state)
      IDLE:
        if (in_valid)
        begin
          vdc1_r <= vdc1;
          vdc2_r <= vdc2;
          iref_r <= iref;
        end
      SCALE:
      begin
        div_dividend <= vdc1_r;
        div_divisor  <= fx_mul(vdc2_r, `TURNS_RATIO);   // vdc2p
      end
      DIV_RATIO:
        if (quot_valid)
          ratio <= quotient;
      FEAS:
      begin
        aux          <= `K_FEAS - fx_mul(iref_r, ratio);
        div_dividend <= fx_mul(iref_r, `K_PHI);
        div_divisor  <= vdc1_r;
      end
      DIV_PHI:
        if (quot_valid)
          phi_rad <= quotient;
      ANGLES:
      begin
        tau1_new <= tau1_code;
        tau2_new <= sat_code(tau2_sum);
        phi_new  <= to_code(fx_mul(phi_rad, `ANGLE_SCALE));
        feasible <= ~aux[`WORD_W-1];
      end
      default:
        ;
    endcase
  end

endmodule

//--- source/mode_select.sv
`timescale 1ns/1ps
`include "dab_consts.svh"

module mode_select
(
  input  logic            clk,
  input  logic            rst,
  input  logic            trigger,
  input  logic            result_valid,
  input  logic            feasible,
  input  dab_pkg::angle_t tau1_new,
  input  dab_pkg::angle_t tau2_new,
  input  dab_pkg::angle_t phi_new,
  output dab_pkg::angle_t tau1,
  output dab_pkg::angle_t tau2,
  output dab_pkg::angle_t phi,
  output dab_pkg::mode_t  modo
);

  import dab_pkg::*;

  logic   trig_s1;
  logic   trig_s2;
  logic   trig_d;
  logic   rise;                         // registered edge
  logic   pend_valid;
  logic   pend_feasible;
  angle_t pend_tau1;
  angle_t pend_tau2;
  angle_t pend_phi;
  logic   apply;

  // tau1 must stay below a full half period
  assign apply = pend_valid && pend_feasible && (pend_tau1 < `TAU_FULL);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      trig_s1    <= 1'b0;
      trig_s2    <= 1'b0;
      trig_d     <= 1'b0;
      rise       <= 1'b0;
      pend_valid <= 1'b0;
      tau1       <= `TAU1_RST;
      tau2       <= `TAU2_RST;
      phi        <= `PHI_RST;
      modo       <= MODE_APPLIED;
    end
    else
    begin
      trig_s1 <= trigger;
      trig_s2 <= trig_s1;
      trig_d  <= trig_s2;
      rise    <= trig_s2 & ~trig_d;
      if (rise)
      begin
        pend_valid <= 1'b0;
        if (apply)
        begin
          tau1 <= pend_tau1;
          tau2 <= pend_tau2;
          phi  <= pend_phi;
          modo <= MODE_APPLIED;
        end
        else
          modo <= MODE_HELD;            // old angles stay
      end
      if (result_valid)
        pend_valid <= 1'b1;             // newest result wins
    end
  end

  always_ff @(posedge clk)
  begin
    if (result_valid)
    begin
      pend_feasible <= feasible;
      pend_tau1     <= tau1_new;
      pend_tau2     <= tau2_new;
      pend_phi      <= phi_new;
    end
  end

endmodule

//--- source/dab_controller.sv
`timescale 1ns/1ps

module dab_controller
(
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  output logic            in_ready,
  input  dab_pkg::fixed_t vdc1,
  input  dab_pkg::fixed_t vdc2,
  input  dab_pkg::fixed_t iref,
  input  dab_pkg::fixed_t fs,
  input  logic            trigger,
  output dab_pkg::angle_t tau1,
  output dab_pkg::angle_t tau2,
  output dab_pkg::angle_t phi,
  output dab_pkg::mode_t  modo
);

  import dab_pkg::*;

  // divider link
  logic   div_valid;
  logic   div_ready;
  fixed_t div_dividend;
  fixed_t div_divisor;
  logic   quot_valid;
  fixed_t quotient;

  // result link
  logic   result_valid;
  logic   feasible;
  angle_t tau1_new;
  angle_t tau2_new;
  angle_t phi_new;

  modulation_calc calc_i
  (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .vdc1         (vdc1),
    .vdc2         (vdc2),
    .iref         (iref),
    .fs           (fs),
    .div_valid    (div_valid),
    .div_ready    (div_ready),
    .div_dividend (div_dividend),
    .div_divisor  (div_divisor),
    .quot_valid   (quot_valid),
    .quotient     (quotient),
    .result_valid (result_valid),
    .feasible     (feasible),
    .tau1_new     (tau1_new),
    .tau2_new     (tau2_new),
    .phi_new      (phi_new)
  );

  fx_divider div_i
  (
    .clk          (clk),
    .rst          (rst),
    .div_valid    (div_valid),
    .div_ready    (div_ready),
    .div_dividend (div_dividend),
    .div_divisor  (div_divisor),
    .quot_valid   (quot_valid),
    .quotient     (quotient)
  );

  mode_select mode_i
  (
    .clk          (clk),
    .rst          (rst),
    .trigger      (trigger),
    .result_valid (result_valid),
    .feasible     (feasible),
    .tau1_new     (tau1_new),
    .tau2_new     (tau2_new),
    .phi_new      (phi_new),
    .tau1         (tau1),
    .tau2         (tau2),
    .phi          (phi),
    .modo         (modo)
  );

endmodule

//--- tests/dab_controller_assertions.sv
`timescale 1ns/1ps

module dab_controller_assertions
(
  input logic            clk,
  input logic            rst,
  input logic            in_valid,
  input logic            in_ready,
  input dab_pkg::fixed_t vdc1,
  input dab_pkg::fixed_t vdc2,
  input dab_pkg::fixed_t iref,
  input dab_pkg::fixed_t fs,
  input logic            result_valid,
  input dab_pkg::angle_t tau1,
  input dab_pkg::mode_t  modo
);

  import dab_pkg::*;

  int fail_count = 0;

  modo_legal: assert property (@(posedge clk) disable iff (rst)
    (modo == MODE_APPLIED) || (modo == MODE_HELD))
  else
  begin
    $error("modo holds an undefined code");
    fail_count++;
  end

  // a load only happens with tau1 below a full half period
  applied_tau1: assert property (@(posedge clk) disable iff (rst)
    (tau1 != $past(tau1)) |-> (modo == MODE_APPLIED) && (tau1 < 255))
  else
  begin
    $error("tau1 loaded at or above a full half period");
    fail_count++;
  end

  input_stable: assert property (@(posedge clk) disable iff (rst)
    (in_valid && !in_ready) |=> in_valid && $stable(vdc1) && $stable(vdc2)
                                && $stable(iref) && $stable(fs))
  else
  begin
    $error("operating point changed while waiting for in_ready");
    fail_count++;
  end

  // busy from acceptance until the cycle after result_valid
  busy_until_result: assert property (@(posedge clk) disable iff (rst)
    (in_valid && in_ready) || (!in_ready && !result_valid) |=> !in_ready)
  else
  begin
    $error("in_ready rose before the result was delivered");
    fail_count++;
  end

endmodule

bind dab_controller dab_controller_assertions assert_i
(
  .clk          (clk),
  .rst          (rst),
  .in_valid     (in_valid),
  .in_ready     (in_ready),
  .vdc1         (vdc1),
  .vdc2         (vdc2),
  .iref         (iref),
  .fs           (fs),
  .result_valid (result_valid),
  .tau1         (tau1),
  .modo         (modo)
);

//--- tests/dab_controller_tb.sv
`timescale 1ns/1ps
`include "dab_consts.svh"

module dab_controller_tb;

  import dab_pkg::*;

  parameter int SEED = 48200;

  localparam int     CLK_PERIOD  = 100;
  localparam int     NUM_RANDOM  = 20;
  localparam int     NUM_POINTS  = NUM_RANDOM + 5;
  localparam longint WATCHDOG_NS = longint'(NUM_POINTS) * 400 * CLK_PERIOD;

  logic   clk;
  logic   rst;
  logic   in_valid;
  logic   in_ready;
  fixed_t vdc1;
  fixed_t vdc2;
  fixed_t iref;
  fixed_t fs;
  logic   trigger;
  angle_t tau1;
  angle_t tau2;
  angle_t phi;
  mode_t  modo;

  int seed;

  // expected outputs and the pending result of the model
  int exp_tau1;
  int exp_tau2;
  int exp_phi;
  int exp_modo;
  bit pend_valid;
  bit pend_feasible;
  int pend_tau1;
  int pend_tau2;
  int pend_phi;

  dab_controller dut_i
  (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .vdc1     (vdc1),
    .vdc2     (vdc2),
    .iref     (iref),
    .fs       (fs),
    .trigger  (trigger),
    .tau1     (tau1),
    .tau2     (tau2),
    .phi      (phi),
    .modo     (modo)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////
  // reference model

  function automatic fixed_t mul_q(input fixed_t a, input fixed_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return fixed_t'(p >>> `FRAC_BITS);
  endfunction

  function automatic fixed_t div_q(input fixed_t a, input fixed_t b);
    longint n;
    if (b == 0)
      return 32'sh7fff_ffff;          // largest positive word
    n = longint'(a) <<< `FRAC_BITS;
    return fixed_t'(n / longint'(b));
  endfunction

  function automatic int clamp_code(input int v);
    if (v > 255)
      return 255;
    if (v < -256)
      return -256;
    return v;
  endfunction

  function automatic int code_of(input fixed_t x);
    return clamp_code(int'(x >>> `FRAC_BITS));
  endfunction

  task automatic predict(input fixed_t v1, input fixed_t v2, input fixed_t ir);
    fixed_t ratio;
    fixed_t aux;
    fixed_t phi_rad;
    fixed_t rest;
    ratio   = div_q(v1, mul_q(v2, `TURNS_RATIO));
    aux     = `K_FEAS - mul_q(ir, ratio);
    phi_rad = div_q(mul_q(ir, `K_PHI), v1);
    rest    = `ONE - ratio;
    pend_valid    = 1'b1;           // newest point replaces the old one
    pend_feasible = (aux >= 0);
    pend_tau1     = code_of(mul_q(ratio, `ANGLE_SCALE));
    pend_tau2     = clamp_code(code_of(mul_q(rest, `ANGLE_SCALE)) + pend_tau1);
    pend_phi      = code_of(mul_q(phi_rad, `ANGLE_SCALE));
  endtask

  task automatic model_trigger;
    if (pend_valid && pend_feasible && pend_tau1 < 255)
    begin
      exp_tau1 = pend_tau1;
      exp_tau2 = pend_tau2;
      exp_phi  = pend_phi;
      exp_modo = 0;
    end
    else
      exp_modo = 3;
    pend_valid = 1'b0;
  endtask

  ////////////////////////////////////////
  // checks

  task automatic check_value(input string name, input int actual, input int expected);
    assert (actual == expected)
    else
    begin
      $display("FAIL at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond)
    else
    begin
      $display("error at %0t: %s", $time, what);
      $display("Test FAILED");
      $fatal(1, "%s", what);
    end
  endtask

  task automatic check_outputs;
    check_value("tau1", int'(tau1), exp_tau1);
    check_value("tau2", int'(tau2), exp_tau2);
    check_value("phi", int'(phi), exp_phi);
    check_value("modo", int'(modo), exp_modo);
  endtask

  ////////////////////////////////////////
  // stimulus

  function automatic fixed_t rand_fixed(input int lo, input int span);
    int unsigned r;
    r = $unsigned($random(seed)) % (span * 65536);
    return fixed_t'(lo * 65536 + int'(r));
  endfunction

  task automatic send_point(input fixed_t v1, input fixed_t v2, input fixed_t ir,
                            input fixed_t f, output int waited);
    @(negedge clk);
    vdc1     = v1;
    vdc2     = v2;
    iref     = ir;
    fs       = f;
    in_valid = 1'b1;
    waited   = 0;
    while (!in_ready)
    begin
      waited++;
      @(negedge clk);
    end
    @(negedge clk);                   // taken at the edge just passed
    in_valid = 1'b0;
    predict(v1, v2, ir);
  endtask

  task automatic wait_result;
    while (!in_ready)
      @(negedge clk);
  endtask

  // outputs move on the third edge after the one that samples trigger
  task automatic pulse_trigger;
    @(negedge clk);
    trigger = 1'b1;
    @(negedge clk);
    trigger = 1'b0;
    @(negedge clk);
    @(negedge clk);
    check_outputs;                    // still the old angles
    model_trigger;
    @(negedge clk);
    check_outputs;
  endtask

  task automatic run_point(input fixed_t v1, input fixed_t v2, input fixed_t ir,
                           input fixed_t f);
    int waited;
    send_point(v1, v2, ir, f, waited);
    wait_result;
    pulse_trigger;
  endtask

  initial
  begin
    int     waited;
    fixed_t r1;
    fixed_t r2;
    fixed_t r3;
    fixed_t r4;
    $timeformat(-9, 0, " ns", 0);
    seed     = SEED;
    rst      = 1'b1;
    in_valid = 1'b0;
    vdc1     = '0;
    vdc2     = '0;
    iref     = '0;
    fs       = '0;
    trigger  = 1'b0;

    exp_tau1      = 255;
    exp_tau2      = 147;
    exp_phi       = -9;
    exp_modo      = 0;
    pend_valid    = 1'b0;
    pend_feasible = 1'b0;
    pend_tau1     = 0;
    pend_tau2     = 0;
    pend_phi      = 0;

    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_outputs;
    check_true(in_ready, "in_ready is low after reset");

    pulse_trigger;                    // nothing pending yet

    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      r1 = rand_fixed(30, 170);       // vdc1
      r2 = rand_fixed(20, 20);        // vdc2
      r3 = rand_fixed(0, 1);          // iref
      r4 = rand_fixed(20, 80);        // fs
      run_point(r1, r2, r3, r4);
    end

    pulse_trigger;                    // result already consumed

    // negative aux, then tau1 saturating at a full half period
    run_point(fixed_t'(100 * 65536), fixed_t'(20 * 65536), fixed_t'(5 * 65536),
              fixed_t'(50 * 65536));
    run_point(fixed_t'(200 * 65536), fixed_t'(5 * 65536), fixed_t'(6554),
              fixed_t'(50 * 65536));

    // second point offered while the first is still running
    send_point(fixed_t'(60 * 65536), fixed_t'(25 * 65536), fixed_t'(32768),
               fixed_t'(40 * 65536), waited);
    send_point(fixed_t'(90 * 65536), fixed_t'(30 * 65536), fixed_t'(45000),
               fixed_t'(60 * 65536), waited);
    check_true(waited >= 2 * (`WORD_W + 2),
               "second point was accepted before the first calculation ended");
    wait_result;
    pulse_trigger;

    // divide by zero in the phase step
    run_point(fixed_t'(0), fixed_t'(20 * 65536), fixed_t'(65536), fixed_t'(50 * 65536));

    if (dut_i.assert_i.fail_count == 0)
    begin
      $display("Test OK");
      $finish;
    end
    else
    begin
      $display("%0d concurrent assertion failures", dut_i.assert_i.fail_count);
      $display("Test FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

//--- sources.f
+incdir+source
source/dab_pkg.sv
source/fx_divider.sv
source/modulation_calc.sv
source/mode_select.sv
source/dab_controller.sv
tests/dab_controller_assertions.sv
tests/dab_controller_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dab_controller_tb
RTL_TOP   ?= dab_controller
SEED      ?= 48200
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

RTL_SRCS = source/dab_pkg.sv source/fx_divider.sv source/modulation_calc.sv \
           source/mode_select.sv source/dab_controller.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall +incdir+source $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
